/* periph_macros.svh */
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

`define APB_AW 32
`define APB_DW 32
`define N_GPIO 8

// slot select in paddr[11:8]
`define SLOT_SOC_CTRL 4'd0
`define SLOT_GPIO     4'd1
`define SLOT_TIMER    4'd2

// register offsets in paddr[7:0]
`define SOC_BOOTADDR_OFS 8'h00
`define SOC_FETCHEN_OFS  8'h04
`define SOC_SOFTRST_OFS  8'h08
`define GPIO_DIR_OFS     8'h00
`define GPIO_OUT_OFS     8'h04
`define GPIO_IN_OFS      8'h08
`define GPIO_INTEN_OFS   8'h0C
`define GPIO_INTSTAT_OFS 8'h10
`define TIM_CTRL_OFS     8'h00
`define TIM_COUNT_OFS    8'h04
`define TIM_CMP_OFS      8'h08

// timer control bits
`define TIM_CTRL_EN_BIT  0
`define TIM_CTRL_REF_BIT 1

`define BOOT_ADDR_RST 32'h1C00_0880

// fc event bit positions
`define EVT_TIMER_MTIME 7
`define EVT_TIMER_LO    16
`define EVT_REF_RISE    18
`define EVT_REF_FALL    19
`define EVT_GPIO        20

`endif

/* periph_pkg.sv */
`include "periph_macros.svh"

package periph_pkg;

  // apb request, master to slave
  typedef struct packed {
    logic [`APB_AW-1:0] paddr;
    logic [`APB_DW-1:0] pwdata;
    logic               pwrite;
    logic               psel;
    logic               penable;
  } apb_req_t;

  // apb response, slave to master
  typedef struct packed {
    logic [`APB_DW-1:0] prdata;
    logic               pready;
    logic               pslverr;
  } apb_rsp_t;

  // fast controller event vector, msb first
  typedef struct packed {
    logic       err;             // 31
    logic [9:0] rsvd_hi;         // 30:21
    logic       gpio_irq;        // 20
    logic       ref_fall;        // 19
    logic       ref_rise;        // 18
    logic       unused_17;       // no hi timer
    logic       timer_irq;       // 16
    logic [7:0] rsvd_mid;        // 15:8
    logic       timer_irq_mtime; // 7
    logic [6:0] rsvd_lo;         // sw events
  } fc_events_t;

endpackage

/* apb_periph_decode.sv */
`timescale 1ns/1ps
`include "periph_macros.svh"

module apb_periph_decode (
  input  periph_pkg::apb_req_t apb_req_i,
  output periph_pkg::apb_rsp_t apb_rsp_o,
  // slot requests
  output periph_pkg::apb_req_t soc_req_o,
  output periph_pkg::apb_req_t gpio_req_o,
  output periph_pkg::apb_req_t tim_req_o,
  // slot responses
  input  periph_pkg::apb_rsp_t soc_rsp_i,
  input  periph_pkg::apb_rsp_t gpio_rsp_i,
  input  periph_pkg::apb_rsp_t tim_rsp_i
);

  logic [3:0] slot;     // paddr[11:8]
  logic       hit_soc;
  logic       hit_gpio;
  logic       hit_tim;
  logic       access;   // access phase of a transfer

  assign slot     = apb_req_i.paddr[11:8];
  assign hit_soc  = (slot == `SLOT_SOC_CTRL);
  assign hit_gpio = (slot == `SLOT_GPIO);
  assign hit_tim  = (slot == `SLOT_TIMER);
  assign access   = apb_req_i.psel & apb_req_i.penable;

  //////////////////////////////////////////////////
  // request fan-out
  //////////////////////////////////////////////////

  // same request everywhere, only psel steered
  always_comb begin
    soc_req_o       = apb_req_i;
    gpio_req_o      = apb_req_i;
    tim_req_o       = apb_req_i;
    soc_req_o.psel  = apb_req_i.psel & hit_soc;
    gpio_req_o.psel = apb_req_i.psel & hit_gpio;
    tim_req_o.psel  = apb_req_i.psel & hit_tim;
  end

  //////////////////////////////////////////////////
  // response merge
  //////////////////////////////////////////////////

  always_comb begin
    // unmapped slot
    apb_rsp_o.prdata  = '0;
    apb_rsp_o.pready  = 1'b1;           // no wait states
    apb_rsp_o.pslverr = access;         // error only in access cycle
    if (hit_soc) begin
      apb_rsp_o = soc_rsp_i;
    end else if (hit_gpio) begin
      apb_rsp_o = gpio_rsp_i;
    end else if (hit_tim) begin
      apb_rsp_o = tim_rsp_i;
    end
  end

endmodule

/* soc_ctrl_regs.sv */
`timescale 1ns/1ps
`include "periph_macros.svh"

module soc_ctrl_regs (
  input  logic                 clk_i,
  input  logic                 rst_n_i,   // hard reset only
  input  periph_pkg::apb_req_t req_i,
  output periph_pkg::apb_rsp_t rsp_o,
  output logic [31:0]          fc_bootaddr_o,
  output logic                 fc_fetchen_o,
  output logic                 periph_rst_n_o  // to gpio and timer
);

  logic [31:0] boot_addr_q;
  logic        fetch_en_q;
  logic        soft_rst_q;   // one cycle wide
  logic        wr_en;
  logic [7:0]  ofs;

  assign ofs   = req_i.paddr[7:0];
  assign wr_en = req_i.psel & req_i.penable & req_i.pwrite;

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      boot_addr_q <= `BOOT_ADDR_RST;
      fetch_en_q  <= 1'b0;
      soft_rst_q  <= 1'b0;
    end else begin
      soft_rst_q <= 1'b0;  // self clearing
      if (wr_en) begin
        case (ofs)
          `SOC_BOOTADDR_OFS: boot_addr_q <= req_i.pwdata;
          `SOC_FETCHEN_OFS:  fetch_en_q  <= req_i.pwdata[0];
          `SOC_SOFTRST_OFS:  soft_rst_q  <= req_i.pwdata[0];
          default: ;  // unknown offset ignored
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////

  always_comb begin
    rsp_o.prdata  = '0;   // unknown offsets and soft reset read 0
    rsp_o.pready  = 1'b1;
    rsp_o.pslverr = 1'b0;
    case (ofs)
      `SOC_BOOTADDR_OFS: rsp_o.prdata = boot_addr_q;
      `SOC_FETCHEN_OFS:  rsp_o.prdata = {31'b0, fetch_en_q};
      default: ;
    endcase
  end

  assign fc_bootaddr_o = boot_addr_q;
  assign fc_fetchen_o  = fetch_en_q;

  // peripherals see hard reset or the soft pulse
  assign periph_rst_n_o = rst_n_i & ~soft_rst_q;

endmodule

/* apb_gpio.sv */
`timescale 1ns/1ps
`include "periph_macros.svh"

module apb_gpio (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  periph_pkg::apb_req_t req_i,
  output periph_pkg::apb_rsp_t rsp_o,
  input  logic [`N_GPIO-1:0]   gpio_in_i,
  output logic [`N_GPIO-1:0]   gpio_out_o,
  output logic [`N_GPIO-1:0]   gpio_oe_o,
  output logic                 gpio_irq_o
);

  localparam int PadW = `APB_DW - `N_GPIO;  // zero fill on reads

  logic [`N_GPIO-1:0] dir_q;
  logic [`N_GPIO-1:0] out_q;
  logic [`N_GPIO-1:0] inten_q;
  logic [`N_GPIO-1:0] intstat_q;  // sticky
  logic [`N_GPIO-1:0] sync1_q;
  logic [`N_GPIO-1:0] sync2_q;    // synced input value
  logic [`N_GPIO-1:0] prev_q;     // sync2 one cycle late
  logic [`N_GPIO-1:0] rise;
  logic [`N_GPIO-1:0] clr;        // w1c mask
  logic               wr_en;
  logic [7:0]         ofs;

  assign ofs   = req_i.paddr[7:0];
  assign wr_en = req_i.psel & req_i.penable & req_i.pwrite;

  //////////////////////////////////////////////////
  // input sync and edge detect
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    sync1_q <= gpio_in_i;
    sync2_q <= sync1_q;
    prev_q  <= sync2_q;
  end

  assign rise = sync2_q & ~prev_q;

  // write one to clear
  assign clr = (wr_en && ofs == `GPIO_INTSTAT_OFS) ? req_i.pwdata[`N_GPIO-1:0] : '0;

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dir_q     <= '0;
      out_q     <= '0;
      inten_q   <= '0;
      intstat_q <= '0;
    end else begin
      intstat_q <= (intstat_q & ~clr) | rise;  // set beats clear
      if (wr_en) begin
        case (ofs)
          `GPIO_DIR_OFS:   dir_q   <= req_i.pwdata[`N_GPIO-1:0];
          `GPIO_OUT_OFS:   out_q   <= req_i.pwdata[`N_GPIO-1:0];
          `GPIO_INTEN_OFS: inten_q <= req_i.pwdata[`N_GPIO-1:0];
          default: ;  // IN is read only, INTSTAT handled above
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////

  always_comb begin
    rsp_o.prdata  = '0;
    rsp_o.pready  = 1'b1;
    rsp_o.pslverr = 1'b0;
    case (ofs)
      `GPIO_DIR_OFS:     rsp_o.prdata = {{PadW{1'b0}}, dir_q};
      `GPIO_OUT_OFS:     rsp_o.prdata = {{PadW{1'b0}}, out_q};
      `GPIO_IN_OFS:      rsp_o.prdata = {{PadW{1'b0}}, sync2_q};
      `GPIO_INTEN_OFS:   rsp_o.prdata = {{PadW{1'b0}}, inten_q};
      `GPIO_INTSTAT_OFS: rsp_o.prdata = {{PadW{1'b0}}, intstat_q};
      default: ;
    endcase
  end

  assign gpio_out_o = out_q;
  assign gpio_oe_o  = dir_q;
  assign gpio_irq_o = |(intstat_q & inten_q);  // level, held until cleared

endmodule

/* apb_timer.sv */
`timescale 1ns/1ps
`include "periph_macros.svh"

module apb_timer (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 slow_clk_i,   // async to clk_i
  input  logic                 stoptimer_i,  // freezes the count
  input  periph_pkg::apb_req_t req_i,
  output periph_pkg::apb_rsp_t rsp_o,
  output logic                 timer_irq_o,
  output logic                 ref_rise_o,
  output logic                 ref_fall_o
);

  logic [2:0]         ref_q;      // two sync flops then delay flop
  logic               ref_rise;
  logic               ref_fall;
  logic               en_q;
  logic               ref_sel_q;  // count on ref_rise instead of clk
  logic [`APB_DW-1:0] count_q;
  logic [`APB_DW-1:0] cmp_q;
  logic               irq_q;
  logic               tick;       // advance event
  logic               match;
  logic               wr_en;
  logic [7:0]         ofs;

  assign ofs   = req_i.paddr[7:0];
  assign wr_en = req_i.psel & req_i.penable & req_i.pwrite;

  //////////////////////////////////////////////////
  // slow clock edges
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    ref_q <= {ref_q[1:0], slow_clk_i};
  end

  assign ref_rise =  ref_q[1] & ~ref_q[2];
  assign ref_fall = ~ref_q[1] &  ref_q[2];

  //////////////////////////////////////////////////
  // counter and compare
  //////////////////////////////////////////////////

  assign tick  = en_q & ~stoptimer_i & (ref_sel_q ? ref_rise : 1'b1);
  assign match = (count_q == cmp_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q      <= 1'b0;
      ref_sel_q <= 1'b0;
      count_q   <= '0;
      cmp_q     <= '0;
      irq_q     <= 1'b0;
    end else begin
      irq_q <= tick & match;  // single cycle pulse
      if (tick) begin
        count_q <= match ? '0 : count_q + 1'b1;  // wrap on compare
      end
      if (wr_en) begin
        case (ofs)
          `TIM_CTRL_OFS: begin
            en_q      <= req_i.pwdata[`TIM_CTRL_EN_BIT];
            ref_sel_q <= req_i.pwdata[`TIM_CTRL_REF_BIT];
          end
          `TIM_COUNT_OFS: count_q <= req_i.pwdata;  // load wins over tick
          `TIM_CMP_OFS:   cmp_q   <= req_i.pwdata;
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////

  always_comb begin
    rsp_o.prdata  = '0;
    rsp_o.pready  = 1'b1;
    rsp_o.pslverr = 1'b0;
    case (ofs)
      `TIM_CTRL_OFS: begin
        rsp_o.prdata[`TIM_CTRL_EN_BIT]  = en_q;
        rsp_o.prdata[`TIM_CTRL_REF_BIT] = ref_sel_q;
      end
      `TIM_COUNT_OFS: rsp_o.prdata = count_q;
      `TIM_CMP_OFS:   rsp_o.prdata = cmp_q;
      default: ;
    endcase
  end

  assign timer_irq_o = irq_q;
  assign ref_rise_o  = ref_rise;
  assign ref_fall_o  = ref_fall;

endmodule

/* soc_peripherals.sv */
`timescale 1ns/1ps
`include "periph_macros.svh"

module soc_peripherals (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   slow_clk_i,
  input  logic                   stoptimer_i,
  input  periph_pkg::apb_req_t   apb_req_i,
  output periph_pkg::apb_rsp_t   apb_rsp_o,
  output logic [31:0]            fc_bootaddr_o,
  output logic                   fc_fetchen_o,
  input  logic [`N_GPIO-1:0]     gpio_in_i,
  output logic [`N_GPIO-1:0]     gpio_out_o,
  output logic [`N_GPIO-1:0]     gpio_oe_o,
  output periph_pkg::fc_events_t fc_events_o
);

  periph_pkg::apb_req_t soc_req, gpio_req, tim_req;
  periph_pkg::apb_rsp_t soc_rsp, gpio_rsp, tim_rsp;

  logic periph_rst_n;  // hard reset and soft reset combined
  logic gpio_irq;
  logic timer_irq;
  logic ref_rise;
  logic ref_fall;

  //////////////////////////////////////////////////
  // bus and control block
  //////////////////////////////////////////////////

  apb_periph_decode i_decode (
    .apb_req_i  (apb_req_i),
    .apb_rsp_o  (apb_rsp_o),
    .soc_req_o  (soc_req),
    .gpio_req_o (gpio_req),
    .tim_req_o  (tim_req),
    .soc_rsp_i  (soc_rsp),
    .gpio_rsp_i (gpio_rsp),
    .tim_rsp_i  (tim_rsp)
  );

  soc_ctrl_regs i_soc_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),      // never soft reset
    .req_i          (soc_req),
    .rsp_o          (soc_rsp),
    .fc_bootaddr_o  (fc_bootaddr_o),
    .fc_fetchen_o   (fc_fetchen_o),
    .periph_rst_n_o (periph_rst_n)
  );

  //////////////////////////////////////////////////
  // peripherals
  //////////////////////////////////////////////////

  apb_gpio i_gpio (
    .clk_i      (clk_i),
    .rst_n_i    (periph_rst_n),
    .req_i      (gpio_req),
    .rsp_o      (gpio_rsp),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o),
    .gpio_irq_o (gpio_irq)
  );

  apb_timer i_timer (
    .clk_i       (clk_i),
    .rst_n_i     (periph_rst_n),
    .slow_clk_i  (slow_clk_i),
    .stoptimer_i (stoptimer_i),
    .req_i       (tim_req),
    .rsp_o       (tim_rsp),
    .timer_irq_o (timer_irq),
    .ref_rise_o  (ref_rise),
    .ref_fall_o  (ref_fall)
  );

  // event vector, dropped sources stay zero
  always_comb begin
    fc_events_o                 = '0;
    fc_events_o.timer_irq_mtime = timer_irq;  // mtime irq
    fc_events_o.timer_irq       = timer_irq;
    fc_events_o.ref_rise        = ref_rise;
    fc_events_o.ref_fall        = ref_fall;
    fc_events_o.gpio_irq        = gpio_irq;   // was i2c slave
  end

endmodule

/* tb_soc_peripherals.sv */
`timescale 1ns/1ps
`include "periph_macros.svh"

module tb_soc_peripherals;

  localparam int Tmo = 64;  // cycle limit for any wait

  logic                   clk;
  logic                   rst_n;
  logic                   slow_clk;
  logic                   stoptimer;
  periph_pkg::apb_req_t   apb_req;
  periph_pkg::apb_rsp_t   apb_rsp;
  logic [31:0]            fc_bootaddr;
  logic                   fc_fetchen;
  logic [`N_GPIO-1:0]     gpio_in;
  logic [`N_GPIO-1:0]     gpio_out;
  logic [`N_GPIO-1:0]     gpio_oe;
  periph_pkg::fc_events_t fc_events;

  logic        slow_en;    // slow clock running
  int          slow_cnt;
  logic [31:0] lcg_state;
  logic [31:0] boot_exp;   // last boot address written
  int          errors;
  int          timeouts;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // slow clock with a half period of 8 clk cycles
  initial begin
    slow_clk = 1'b0;
    slow_cnt = 0;
    forever begin
      @(negedge clk);
      if (!slow_en) begin
        slow_clk = 1'b0;
        slow_cnt = 0;
      end else if (slow_cnt == 7) begin
        slow_clk = ~slow_clk;
        slow_cnt = 0;
      end else begin
        slow_cnt++;
      end
    end
  end

  soc_peripherals uut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .slow_clk_i    (slow_clk),
    .stoptimer_i   (stoptimer),
    .apb_req_i     (apb_req),
    .apb_rsp_o     (apb_rsp),
    .fc_bootaddr_o (fc_bootaddr),
    .fc_fetchen_o  (fc_fetchen),
    .gpio_in_i     (gpio_in),
    .gpio_out_o    (gpio_out),
    .gpio_oe_o     (gpio_oe),
    .fc_events_o   (fc_events)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] reg_addr(input logic [3:0] slot, input logic [7:0] ofs);
    return {20'h0, slot, ofs};  // slot in 11:8
  endfunction

  function automatic periph_pkg::apb_rsp_t make_rsp(input logic [31:0] data, input logic err);
    periph_pkg::apb_rsp_t r;
    r.prdata  = data;
    r.pready  = 1'b1;  // never a wait state
    r.pslverr = err;
    return r;
  endfunction

  task automatic check_rsp(input periph_pkg::apb_rsp_t got, input periph_pkg::apb_rsp_t exp,
                           input string msg);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s, got %h/%b/%b expected %h/%b/%b", $time, msg,
               got.prdata, got.pready, got.pslverr, exp.prdata, exp.pready, exp.pslverr);
    end
  endtask

  task automatic check_events(input periph_pkg::fc_events_t got,
                              input periph_pkg::fc_events_t exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s, events %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  // write commits at the edge that closes the access phase
  task automatic apb_xfer(input logic [31:0] addr, input logic [31:0] wdata, input logic write,
                          output periph_pkg::apb_rsp_t rsp);
    int n;
    @(negedge clk);
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    apb_req.pwrite  = write;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #1;  // let the read mux settle
    n = 0;
    while (!apb_rsp.pready && n < Tmo) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!apb_rsp.pready) begin
      timeouts++;
      $display("timeout: slave never raised pready for address %h", addr);
    end
    rsp = apb_rsp;
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
    periph_pkg::apb_rsp_t rsp;
    apb_xfer(addr, data, 1'b1, rsp);
  endtask

  task automatic apb_read(input logic [31:0] addr, output periph_pkg::apb_rsp_t rsp);
    apb_xfer(addr, 32'h0, 1'b0, rsp);
  endtask

  task automatic read_and_compare(input logic [31:0] addr, input logic [31:0] exp,
                                  input string msg);
    periph_pkg::apb_rsp_t rsp;
    apb_read(addr, rsp);
    check_rsp(rsp, make_rsp(exp, 1'b0), msg);
  endtask

  task automatic wait_event(input int idx, input string what);
    int n;
    n = 0;
    while (!fc_events[idx] && n < Tmo) begin
      @(negedge clk);
      n++;
    end
    if (!fc_events[idx]) begin
      timeouts++;
      $display("timeout: %s did not show up within %0d cycles", what, Tmo);
    end
  endtask

  // poll a register until it holds the value
  task automatic wait_reg(input logic [31:0] addr, input logic [31:0] exp, input string what);
    periph_pkg::apb_rsp_t rsp;
    int n;
    n = 0;
    apb_read(addr, rsp);
    while (rsp.prdata !== exp && n < 16) begin
      apb_read(addr, rsp);
      n++;
    end
    if (rsp.prdata !== exp) begin
      timeouts++;
      $display("timeout: %s never read back as %h", what, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic reset_values();
    check_word(fc_bootaddr, `BOOT_ADDR_RST, "boot address after reset");
    check_word({31'b0, fc_fetchen}, 32'h0, "fetch enable after reset");
    check_word({24'b0, gpio_out}, 32'h0, "gpio out after reset");
    check_word({24'b0, gpio_oe}, 32'h0, "gpio oe after reset");
    check_events(fc_events, '0, "events after reset");
    read_and_compare(reg_addr(`SLOT_SOC_CTRL, `SOC_BOOTADDR_OFS), `BOOT_ADDR_RST,
                     "boot address readback after reset");
  endtask

  task automatic soc_ctrl_access();
    periph_pkg::apb_rsp_t rsp;
    repeat (3) begin
      boot_exp = next_rand();
      apb_write(reg_addr(`SLOT_SOC_CTRL, `SOC_BOOTADDR_OFS), boot_exp);
      read_and_compare(reg_addr(`SLOT_SOC_CTRL, `SOC_BOOTADDR_OFS), boot_exp, "boot readback");
      check_word(fc_bootaddr, boot_exp, "boot address output");
    end
    apb_write(reg_addr(`SLOT_SOC_CTRL, `SOC_FETCHEN_OFS), 32'h1);
    check_word({31'b0, fc_fetchen}, 32'h1, "fetch enable output");
    apb_read(reg_addr(4'd5, 8'h00), rsp);  // no slot 5
    check_rsp(rsp, make_rsp(32'h0, 1'b1), "unmapped slot");
    read_and_compare(reg_addr(`SLOT_SOC_CTRL, 8'h40), 32'h0, "unknown soc offset");
    read_and_compare(reg_addr(`SLOT_TIMER, 8'h0C), 32'h0, "unknown timer offset");
  endtask

  task automatic gpio_pins_and_irq();
    periph_pkg::fc_events_t exp_evt;
    logic [31:0] d;
    logic [31:0] o;
    d = next_rand();
    o = next_rand();
    apb_write(reg_addr(`SLOT_GPIO, `GPIO_DIR_OFS), d);
    apb_write(reg_addr(`SLOT_GPIO, `GPIO_OUT_OFS), o);
    check_word({24'b0, gpio_oe}, {24'b0, d[7:0]}, "gpio oe from direction");
    check_word({24'b0, gpio_out}, {24'b0, o[7:0]}, "gpio out pins");
    read_and_compare(reg_addr(`SLOT_GPIO, `GPIO_DIR_OFS), {24'b0, d[7:0]}, "direction readback");
    @(negedge clk);
    gpio_in = 8'h5A;
    wait_reg(reg_addr(`SLOT_GPIO, `GPIO_IN_OFS), 32'h5A, "gpio input");
    apb_write(reg_addr(`SLOT_GPIO, `GPIO_INTSTAT_OFS), 32'hFF);  // drop edges of 5A
    read_and_compare(reg_addr(`SLOT_GPIO, `GPIO_INTSTAT_OFS), 32'h0, "status cleared");
    apb_write(reg_addr(`SLOT_GPIO, `GPIO_INTEN_OFS), 32'h05);   // pins 0 and 2
    @(negedge clk);
    gpio_in = 8'h5B;  // pin 0 rises
    wait_event(`EVT_GPIO, "gpio interrupt");
    exp_evt = '0;
    exp_evt.gpio_irq = 1'b1;
    check_events(fc_events, exp_evt, "gpio irq only");
    read_and_compare(reg_addr(`SLOT_GPIO, `GPIO_INTSTAT_OFS), 32'h01, "status of pin 0");
    apb_write(reg_addr(`SLOT_GPIO, `GPIO_INTSTAT_OFS), 32'h01);
    check_events(fc_events, '0, "irq low after clear");
    @(negedge clk);
    gpio_in = 8'hDB;  // pin 7 rises while disabled
    wait_reg(reg_addr(`SLOT_GPIO, `GPIO_INTSTAT_OFS), 32'h80, "status of pin 7");
    check_events(fc_events, '0, "disabled pin gives no irq");
    apb_write(reg_addr(`SLOT_GPIO, `GPIO_INTSTAT_OFS), 32'hFF);
  endtask

  task automatic timer_clock_mode();
    periph_pkg::fc_events_t exp_evt;
    periph_pkg::apb_rsp_t r0;
    periph_pkg::apb_rsp_t r1;
    logic [31:0] n;
    int cyc;
    n = next_rand() % 32;
    if (n < 3) n = n + 3;  // period longer than the count read gap below
    apb_write(reg_addr(`SLOT_TIMER, `TIM_CMP_OFS), n);
    apb_write(reg_addr(`SLOT_TIMER, `TIM_CTRL_OFS), 32'h1);
    wait_event(`EVT_TIMER_LO, "first timer irq");
    exp_evt = '0;
    exp_evt.timer_irq = 1'b1;
    exp_evt.timer_irq_mtime = 1'b1;
    check_events(fc_events, exp_evt, "timer irq on bits 7 and 16");
    cyc = 0;
    do begin
      @(negedge clk);
      cyc++;
      if (cyc == 1) check_events(fc_events, '0, "timer irq one cycle wide");
    end while (!fc_events.timer_irq && cyc < Tmo);
    if (!fc_events.timer_irq) begin
      timeouts++;
      $display("timeout: second timer irq did not show up within %0d cycles", Tmo);
    end else begin
      check_word(cyc, n + 1, "timer irq period");
    end
    @(negedge clk);
    stoptimer = 1'b1;
    apb_read(reg_addr(`SLOT_TIMER, `TIM_COUNT_OFS), r0);
    apb_read(reg_addr(`SLOT_TIMER, `TIM_COUNT_OFS), r1);
    check_word(r1.prdata, r0.prdata, "count frozen by stoptimer");
    stoptimer = 1'b0;
    apb_write(reg_addr(`SLOT_TIMER, `TIM_CTRL_OFS), 32'h0);
  endtask

  task automatic timer_ref_mode();
    periph_pkg::fc_events_t exp_evt;
    periph_pkg::apb_rsp_t r0;
    periph_pkg::apb_rsp_t r1;
    int rises;
    int falls;
    int i;
    slow_en = 1'b1;
    wait_event(`EVT_REF_RISE, "first ref rise");
    rises = 0;
    falls = 0;
    repeat (16) begin  // one slow period
      @(negedge clk);
      if (fc_events.ref_rise) rises++;
      if (fc_events.ref_fall) falls++;
    end
    check_word(rises, 32'd1, "ref rise pulses per period");
    check_word(falls, 32'd1, "ref fall pulses per period");
    apb_write(reg_addr(`SLOT_TIMER, `TIM_COUNT_OFS), 32'h0);
    apb_write(reg_addr(`SLOT_TIMER, `TIM_CMP_OFS), 32'h2);
    wait_event(`EVT_REF_RISE, "ref rise before enable");
    apb_write(reg_addr(`SLOT_TIMER, `TIM_CTRL_OFS), 32'h3);  // enable and ref select
    for (i = 1; i <= 3; i++) begin
      exp_evt = '0;
      exp_evt.timer_irq = (i == 3);
      exp_evt.timer_irq_mtime = (i == 3);
      wait_event(`EVT_REF_RISE, "ref rise while counting");
      @(negedge clk);
      check_events(fc_events, exp_evt, "timer irq only after third rise");
      apb_read(reg_addr(`SLOT_TIMER, `TIM_COUNT_OFS), r0);
      apb_read(reg_addr(`SLOT_TIMER, `TIM_COUNT_OFS), r1);
      check_word(r0.prdata, i % 3, "count after ref rise");
      check_word(r1.prdata, r0.prdata, "count steady between rises");
    end
  endtask

  task automatic soft_reset_keeps_soc();
    slow_en = 1'b0;
    apb_write(reg_addr(`SLOT_GPIO, `GPIO_DIR_OFS), 32'hA5);
    apb_write(reg_addr(`SLOT_GPIO, `GPIO_OUT_OFS), 32'h3C);
    apb_write(reg_addr(`SLOT_GPIO, `GPIO_INTEN_OFS), 32'h0F);
    apb_write(reg_addr(`SLOT_TIMER, `TIM_CMP_OFS), 32'd100);
    apb_write(reg_addr(`SLOT_TIMER, `TIM_CTRL_OFS), 32'h1);
    apb_write(reg_addr(`SLOT_SOC_CTRL, `SOC_SOFTRST_OFS), 32'h1);
    read_and_compare(reg_addr(`SLOT_SOC_CTRL, `SOC_SOFTRST_OFS), 32'h0, "soft reset reads 0");
    read_and_compare(reg_addr(`SLOT_GPIO, `GPIO_DIR_OFS), 32'h0, "direction after soft reset");
    read_and_compare(reg_addr(`SLOT_GPIO, `GPIO_OUT_OFS), 32'h0, "out after soft reset");
    read_and_compare(reg_addr(`SLOT_GPIO, `GPIO_INTEN_OFS), 32'h0, "enable after soft reset");
    read_and_compare(reg_addr(`SLOT_TIMER, `TIM_CTRL_OFS), 32'h0, "timer ctrl after soft reset");
    read_and_compare(reg_addr(`SLOT_TIMER, `TIM_COUNT_OFS), 32'h0, "count after soft reset");
    check_word({24'b0, gpio_out}, 32'h0, "gpio out pins after soft reset");
    check_word({24'b0, gpio_oe}, 32'h0, "gpio oe pins after soft reset");
    read_and_compare(reg_addr(`SLOT_SOC_CTRL, `SOC_BOOTADDR_OFS), boot_exp, "boot addr kept");
    check_word({31'b0, fc_fetchen}, 32'h1, "fetch enable kept");
  endtask

  //////////////////////////////////////////////////
  // sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n     = 1'b0;
    stoptimer = 1'b0;
    gpio_in   = '0;
    apb_req   = '0;
    slow_en   = 1'b0;
    lcg_state = 32'h7fdb2b30;
    boot_exp  = `BOOT_ADDR_RST;
    errors    = 0;
    timeouts  = 0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    reset_values();
    soc_ctrl_access();
    gpio_pins_and_irq();
    timer_clock_mode();
    timer_ref_mode();
    soft_reset_keeps_soc();
    $display("errors: %0d  timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+.
periph_pkg.sv
apb_periph_decode.sv
soc_ctrl_regs.sv
apb_gpio.sv
apb_timer.sv
soc_peripherals.sv
tb_soc_peripherals.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_soc_peripherals -f all.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "run.sh: testbench reported failure"
  exit 1
fi
echo "run.sh: no failure reported"
exit 0
